// ==== hdl/data_cache.sv ====
module data_cache
  import dcache_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    access,
  input  mem_op_e op,
  input  logic    byte_op,
  input  addr_t   address,
  input  word_t   data_in,
  output word_t   data_out,
  output logic    data_ready,
  mem_line_if.cache mem
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITEBACK,
    ST_FILL,
    ST_RESPOND
  } state_e;

  // per set storage
  logic [TAG_W-1:0]    tag_arr [NUM_SETS];
  line_t               line_arr [NUM_SETS];
  logic [NUM_SETS-1:0] valid_arr;
  logic [NUM_SETS-1:0] dirty_arr;

  state_e state;

  // high from a start strobe until the matching completion
  logic mem_pending;

  // request address split
  logic [INDEX_W-1:0] idx;
  logic [TAG_W-1:0]   tag;
  logic [WSEL_W-1:0]  word_sel;
  logic [BSEL_W-1:0]  byte_sel;

  // selected line, word, byte and the write merge
  line_t       cur_line;
  word_t       cur_word;
  logic [7:0]  cur_byte;
  word_t       new_word;
  line_t       new_line;

  logic hit;
  logic victim_dirty;
  logic new_req;
  logic serve;
  logic miss_start;
  logic fill_done;
  logic wb_done;

  assign idx      = address[OFFSET_W +: INDEX_W];
  assign tag      = address[ADDR_W-1 -: TAG_W];
  assign word_sel = address[BSEL_W +: WSEL_W];
  assign byte_sel = address[BSEL_W-1:0];

  always_comb
  begin
    cur_line = line_arr[idx];
    cur_word = cur_line[word_sel*WORD_W +: WORD_W];
    cur_byte = cur_word[byte_sel*8 +: 8];
    // byte store touches one lane only
    new_word = cur_word;
    if (byte_op)
    begin
      new_word[byte_sel*8 +: 8] = data_in[7:0];
    end
    else
    begin
      new_word = data_in;
    end
    new_line = cur_line;
    new_line[word_sel*WORD_W +: WORD_W] = new_word;
  end

  assign hit          = valid_arr[idx] && (tag_arr[idx] == tag);
  assign victim_dirty = valid_arr[idx] && dirty_arr[idx];

  // held request is ignored during its own ready cycle
  assign new_req    = (state == ST_IDLE) && access && !data_ready;
  assign serve      = (new_req && hit) || (state == ST_RESPOND);
  assign miss_start = new_req && !hit;
  assign fill_done  = (state == ST_FILL) && mem.data_ready;
  assign wb_done    = (state == ST_WRITEBACK) && mem.data_ready;

  // controller and status bits
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state       <= ST_IDLE;
      valid_arr   <= '0;
      dirty_arr   <= '0;
      data_ready  <= 1'b0;
      mem.op_init <= 1'b0;
      mem_pending <= 1'b0;
    end
    else
    begin
      data_ready  <= serve;
      mem.op_init <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (miss_start)
          begin
            mem.op_init <= 1'b1;
            // dirty victim goes out before the fill
            state <= victim_dirty ? ST_WRITEBACK : ST_FILL;
          end
        end
        ST_WRITEBACK:
        begin
          if (wb_done)
          begin
            mem.op_init <= 1'b1;
            state       <= ST_FILL;
          end
        end
        ST_FILL:
        begin
          if (fill_done)
          begin
            valid_arr[idx] <= 1'b1;
            dirty_arr[idx] <= 1'b0;
            state          <= ST_RESPOND;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
      if (serve && op == MEM_WRITE)
      begin
        dirty_arr[idx] <= 1'b1;
      end
      if (mem.op_init)
      begin
        mem_pending <= 1'b1;
      end
      else if (mem.data_ready)
      begin
        mem_pending <= 1'b0;
      end
    end
  end

  // line storage, read data and memory request fields
  always_ff @(posedge clk)
  begin
    if (fill_done)
    begin
      line_arr[idx] <= mem.rdata;
      tag_arr[idx]  <= tag;
    end
    else if (serve && op == MEM_WRITE)
    begin
      line_arr[idx] <= new_line;
    end
    if (serve)
    begin
      // byte loads are zero extended
      data_out <= byte_op ? {{(WORD_W-8){1'b0}}, cur_byte} : cur_word;
    end
    if (miss_start && victim_dirty)
    begin
      // victim lives at its own tag's line address
      mem.op        <= MEM_WRITE;
      mem.line_addr <= {tag_arr[idx], idx};
      mem.wdata     <= cur_line;
    end
    else if (miss_start || wb_done)
    begin
      mem.op        <= MEM_READ;
      mem.line_addr <= address[ADDR_W-1:OFFSET_W];
    end
  end

  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    access && !byte_op |-> address[BSEL_W-1:0] == '0)
    else $error("data_cache: unaligned word access at %h", address);

  // one memory access in flight at a time
  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    mem.op_init |-> !mem_pending)
    else $error("data_cache: op_init while a memory access is outstanding");

  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    data_ready |=> !data_ready)
    else $error("data_cache: data_ready high for two cycles");

endmodule

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

  // processor side address and data
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // one cache line holds four words
  localparam int LINE_W = 128;
  localparam int OFFSET_W = 4;

  // byte within word, word within line
  localparam int BSEL_W = $clog2(WORD_W / 8);
  localparam int WSEL_W = OFFSET_W - BSEL_W;

  // direct mapped geometry
  localparam int INDEX_W = 4;
  localparam int NUM_SETS = 1 << INDEX_W;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // line address seen by main memory, byte address minus offset
  localparam int LADDR_W = ADDR_W - OFFSET_W;

  // main memory depth in lines, 16 KiB
  localparam int MEM_LINES = 1024;
  localparam int MEM_IDX_W = $clog2(MEM_LINES);

  // start pulse to ready pulse, in cycles
  // counter scheme needs at least 2
  localparam int MEM_LATENCY = 5;
  localparam int LAT_CNT_W = $clog2(MEM_LATENCY);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [LADDR_W-1:0] line_addr_t;

  // shared by the processor port and the memory bus
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

endpackage

// ==== hdl/dmem_subsystem.sv ====
module dmem_subsystem
  import dcache_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    access,
  input  mem_op_e op,
  input  logic    byte_op,
  input  addr_t   address,
  input  word_t   data_in,
  output word_t   data_out,
  output logic    data_ready
);

  // cache to memory line bus
  mem_line_if mem_bus (
    .clk (clk)
  );

  // processor facing cache
  data_cache u_cache (
    .clk        (clk),
    .rst_n      (rst_n),
    .access     (access),
    .op         (op),
    .byte_op    (byte_op),
    .address    (address),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_ready (data_ready),
    .mem        (mem_bus.cache)
  );

  // slow backing store
  main_memory u_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (mem_bus.memory)
  );

endmodule

// ==== hdl/main_memory.sv ====
module main_memory
  import dcache_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  mem_line_if.memory mem
);

  // line wide storage, left as is through reset
  line_t storage [MEM_LINES];

  // latency counter
  logic                 busy;
  logic [LAT_CNT_W-1:0] count;
  logic                 finish;

  // request captured at the start strobe
  mem_op_e              req_op;
  logic [MEM_IDX_W-1:0] req_idx;
  line_t                req_wdata;

  // last counted cycle, ready goes out on the next one
  assign finish = busy && (count == LAT_CNT_W'(1));

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy           <= 1'b0;
      count          <= '0;
      mem.data_ready <= 1'b0;
    end
    else
    begin
      mem.data_ready <= finish;
      if (mem.op_init)
      begin
        busy  <= 1'b1;
        // strobe cycle counts as the first one
        count <= LAT_CNT_W'(MEM_LATENCY - 1);
      end
      else if (finish)
      begin
        busy <= 1'b0;
      end
      else if (busy)
      begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (mem.op_init)
    begin
      req_op    <= mem.op;
      // line address wraps at the memory depth
      req_idx   <= mem.line_addr[MEM_IDX_W-1:0];
      req_wdata <= mem.wdata;
    end
    if (finish)
    begin
      if (req_op == MEM_WRITE)
      begin
        storage[req_idx] <= req_wdata;
      end
      else
      begin
        mem.rdata <= storage[req_idx];
      end
    end
  end

  // requester waits for completion before the next start
  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    mem.op_init |-> !busy)
    else $error("main_memory: op_init while an access is in progress");

endmodule

// ==== hdl/mem_line_if.sv ====
interface mem_line_if
  import dcache_pkg::*;
(
  input logic clk
);

  // request side, driven by the cache
  // op_init is a single cycle start strobe
  logic       op_init;
  mem_op_e    op;
  line_addr_t line_addr;
  line_t      wdata;

  // response side, driven by the memory
  line_t      rdata;
  logic       data_ready;

  modport cache (
    input  clk,
    output op_init, op, line_addr, wdata,
    input  rdata, data_ready
  );

  modport memory (
    input  clk,
    input  op_init, op, line_addr, wdata,
    output rdata, data_ready
  );

  // a new start only comes after the previous completion cycle
  a_no_start_on_done: assert property (@(posedge clk) !(op_init && data_ready))
    else $error("mem bus: op_init and data_ready high in the same cycle");

endinterface

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator
# exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f src.f --top-module tb_dmem_subsystem -o tb_dmem_subsystem
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

if [ ! -x ./obj_dir/tb_dmem_subsystem ]; then
  echo "simulation executable not found"
  exit 1
fi

./obj_dir/tb_dmem_subsystem
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
else
  echo "simulation finished with status 0"
fi
exit "$status"

// ==== src.f ====
hdl/dcache_pkg.sv
hdl/mem_line_if.sv
hdl/data_cache.sv
hdl/main_memory.sv
hdl/dmem_subsystem.sv
testbench/tb_dmem_subsystem.sv

// ==== testbench/tb_dmem_subsystem.sv ====
module tb_dmem_subsystem
  import dcache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int NUM_RANDOM = 300;
  // tested byte space of 16 KiB
  localparam int SPACE = 16384;

  logic    clk;
  logic    rst_n;
  logic    access;
  mem_op_e op;
  logic    byte_op;
  addr_t   address;
  word_t   data_in;
  word_t   data_out;
  logic    data_ready;

  // shadow bytes and which of them hold known data
  logic [7:0] shadow [SPACE];
  bit         written [SPACE];

  // direct mapped mirror of the cache tags
  logic [TAG_W-1:0] model_tag [NUM_SETS];
  bit               model_valid [NUM_SETS];

  // expectations for the request in flight
  logic  exp_hit;
  logic  exp_is_read;
  word_t exp_data;
  logic  pending_req;
  logic  started;
  logic  clk_started;
  int    req_count;
  int    ready_count;

  dmem_subsystem uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .access     (access),
    .op         (op),
    .byte_op    (byte_op),
    .address    (address),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_ready (data_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // data_ready is unknown before the first edge
  always @(posedge clk)
  begin
    clk_started <= 1'b1;
  end

  // one count per ready pulse
  always @(negedge clk)
  begin
    if (data_ready)
    begin
      ready_count = ready_count + 1;
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  // address is {tag, index, offset}
  // second tag of a set differs in several bits
  function automatic addr_t make_addr(input int set, input bit alt_tag, input int offset);
    logic [5:0] tag6;
    tag6 = alt_tag ? (6'(set) ^ 6'h2a) : 6'(set);
    return addr_t'({tag6, 4'(set), 4'(offset)});
  endfunction

  function automatic bit is_readable(input addr_t a, input logic as_byte);
    int base;
    base = int'(a);
    if (as_byte)
    begin
      return written[base];
    end
    return written[base] && written[base+1] && written[base+2] && written[base+3];
  endfunction

  // little endian with byte loads zero extended
  function automatic word_t expected_read(input addr_t a, input logic as_byte);
    int base;
    base = int'(a);
    if (as_byte)
    begin
      return {24'b0, shadow[base]};
    end
    return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
  endfunction

  task automatic record_write(input addr_t a, input logic as_byte, input word_t d);
    int base;
    int n;
    base = int'(a);
    if (as_byte)
    begin
      shadow[base]  = d[7:0];
      written[base] = 1'b1;
    end
    else
    begin
      for (n = 0; n < 4; n++)
      begin
        shadow[base+n]  = d[n*8 +: 8];
        written[base+n] = 1'b1;
      end
    end
  endtask

  // one processor access, held until its ready pulse
  task automatic do_request(input mem_op_e req_op, input logic as_byte,
                            input addr_t req_addr, input word_t req_data);
    int               set;
    logic [TAG_W-1:0] req_tag;
    int               waited;
    set     = int'(req_addr[OFFSET_W +: INDEX_W]);
    req_tag = req_addr[ADDR_W-1 -: TAG_W];
    // access was low at the edge before this one
    @(negedge clk);
    exp_hit     = model_valid[set] && (model_tag[set] == req_tag);
    exp_is_read = (req_op == MEM_READ);
    if (exp_is_read)
    begin
      exp_data = expected_read(req_addr, as_byte);
    end
    else
    begin
      record_write(req_addr, as_byte, req_data);
    end
    // the set now holds this line
    model_valid[set] = 1'b1;
    model_tag[set]   = req_tag;
    access      = 1'b1;
    op          = req_op;
    byte_op     = as_byte;
    address     = req_addr;
    data_in     = req_data;
    pending_req = 1'b1;
    started     = 1'b1;
    req_count   = req_count + 1;
    waited = 0;
    while (!data_ready)
    begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES)
      begin
        fail_now($sformatf("timeout: no data_ready within %0d cycles for access to %h",
                           TIMEOUT_CYCLES, req_addr));
      end
    end
    // drop during the ready cycle
    access      = 1'b0;
    pending_req = 1'b0;
  endtask

  // quiet through reset and until the first request
  a_idle_ready: assert property (@(posedge clk) clk_started && !started |-> !data_ready)
    else fail_now($sformatf("[ERROR] %0t data_ready: expected 0, got %b",
                            $time, $sampled(data_ready)));

  // predicted hit answers on the next cycle
  a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(access) && exp_hit |=> data_ready)
    else fail_now($sformatf("[ERROR] %0t data_ready: expected 1, got %b",
                            $time, $sampled(data_ready)));

  // predicted miss must go to memory
  a_miss_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(access) && !exp_hit |=> !data_ready)
    else fail_now($sformatf("[ERROR] %0t data_ready: expected 0, got %b",
                            $time, $sampled(data_ready)));

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    data_ready && exp_is_read |-> data_out == exp_data)
    else fail_now($sformatf("[ERROR] %0t data_out: expected %h, got %h",
                            $time, exp_data, $sampled(data_out)));

  // no pulse unless a request was held at the edge before
  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    data_ready |-> $past(pending_req))
    else fail_now($sformatf("[ERROR] %0t data_ready: expected 0, got %b",
                            $time, $sampled(data_ready)));

  initial
  begin
    int      set;
    int      n;
    int      offset;
    bit      alt;
    logic    as_byte;
    addr_t   req_addr;
    mem_op_e req_op;
    void'($urandom(32'h2e10_6bc0));
    rst_n       = 1'b0;
    access      = 1'b0;
    op          = MEM_READ;
    byte_op     = 1'b0;
    address     = '0;
    data_in     = '0;
    exp_hit     = 1'b0;
    exp_is_read = 1'b0;
    exp_data    = '0;
    pending_req = 1'b0;
    started     = 1'b0;
    clk_started = 1'b0;
    req_count   = 0;
    ready_count = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    // first touch of every set while all lines are invalid
    for (set = 0; set < NUM_SETS; set++)
    begin
      do_request(MEM_WRITE, 1'b0, make_addr(set, 1'b0, 0), $urandom());
    end
    // word write then read back on a hit
    do_request(MEM_WRITE, 1'b0, make_addr(5, 1'b0, 8), 32'hcafe_0123);
    do_request(MEM_READ, 1'b0, make_addr(5, 1'b0, 8), '0);
    // byte merge into lane 1 then word and byte reads
    do_request(MEM_WRITE, 1'b1, make_addr(5, 1'b0, 9), 32'h0000_00a5);
    do_request(MEM_READ, 1'b0, make_addr(5, 1'b0, 8), '0);
    do_request(MEM_READ, 1'b1, make_addr(5, 1'b0, 9), '0);
    // dirty line pushed out by the other tag and fetched again
    do_request(MEM_WRITE, 1'b0, make_addr(3, 1'b0, 4), 32'h1234_5678);
    do_request(MEM_WRITE, 1'b0, make_addr(3, 1'b1, 12), 32'h9abc_def0);
    do_request(MEM_READ, 1'b0, make_addr(3, 1'b0, 4), '0);
    do_request(MEM_READ, 1'b0, make_addr(3, 1'b1, 12), '0);
    // random mix over two tags per set
    for (n = 0; n < NUM_RANDOM; n++)
    begin
      set     = int'($urandom_range(NUM_SETS - 1, 0));
      alt     = 1'($urandom_range(1, 0));
      as_byte = 1'($urandom_range(1, 0));
      offset  = as_byte ? int'($urandom_range(15, 0)) : 4 * int'($urandom_range(3, 0));
      req_addr = make_addr(set, alt, offset);
      req_op   = ($urandom_range(1, 0) == 1) ? MEM_READ : MEM_WRITE;
      // unknown bytes are written first
      if (req_op == MEM_READ && !is_readable(req_addr, as_byte))
      begin
        req_op = MEM_WRITE;
      end
      do_request(req_op, as_byte, req_addr, $urandom());
    end
    repeat (4) @(negedge clk);
    if (ready_count != req_count)
    begin
      fail_now($sformatf("[ERROR] %0t ready pulse count: expected %0d, got %0d",
                         $time, req_count, ready_count));
    end
    else
    begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule
